// File: Makefile
TOP = tb_picorv_mem

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --timescale 1ns/100ps -f picorv_mem.f --top-module $(TOP) -o sim
	./obj_dir/sim | tee sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: byte_lane_ram.sv
`timescale 1ns/100ps
`default_nettype none

module byte_lane_ram (
  input  wire                               clk,
  // Bus port
  input  wire [picorv_mem_pkg::strb_w-1:0]  ram_we,
  input  wire [picorv_mem_pkg::ram_aw-1:0]  ram_addr,
  input  wire [picorv_mem_pkg::data_w-1:0]  ram_wdata,
  output logic [picorv_mem_pkg::data_w-1:0] ram_rdata,
  // Program loader port
  input  wire                               cfg_wr_en,
  input  wire [picorv_mem_pkg::ram_aw+1:0]  cfg_addr,
  input  wire [7:0]                         cfg_din
);

  logic [picorv_mem_pkg::ram_aw-1:0] cfg_word;
  logic [1:0]                        cfg_lane;

  assign cfg_word = cfg_addr[picorv_mem_pkg::ram_aw+1:2];  // Byte address to word index
  assign cfg_lane = cfg_addr[1:0];

  for (genvar i = 0; i < picorv_mem_pkg::strb_w; i++) begin : g_lane
    logic [7:0] mem [picorv_mem_pkg::ram_words];  // One byte lane
    logic [7:0] rd_q;

    always_ff @(posedge clk) begin
      if (ram_we[i]) begin
        mem[ram_addr] <= ram_wdata[8*i +: 8];
      end
      // Loader write comes last, so it wins on a shared word
      if (cfg_wr_en && cfg_lane == 2'(i)) begin
        mem[cfg_word] <= cfg_din;
      end
      rd_q <= mem[ram_addr];  // Read-first, one cycle latency
    end

    assign ram_rdata[8*i +: 8] = rd_q;
  end

endmodule

`default_nettype wire

// File: cycle_irq_timer.sv
`timescale 1ns/100ps
`default_nettype none

module cycle_irq_timer (
  input  wire         clk,
  input  wire         resetn,
  output logic [31:0] irq
);

  logic [picorv_mem_pkg::slow_period_log2-1:0] count_cycle;  // Free-running, wraps

  always_ff @(posedge clk) begin
    if (!resetn) count_cycle <= '0;
    else         count_cycle <= count_cycle + 1'b1;
  end

  always_comb begin
    irq = '0;
    irq[picorv_mem_pkg::irq_fast_bit] = &count_cycle[picorv_mem_pkg::fast_period_log2-1:0];
    irq[picorv_mem_pkg::irq_slow_bit] = &count_cycle;  // Once per full wrap
  end

endmodule

`default_nettype wire

// File: mem_bus_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module mem_bus_ctrl (
  input  wire                                          clk,
  input  wire                                          resetn,
  input  wire                                          mem_valid,
  input  wire [31:0]                                   mem_addr,
  input  wire [picorv_mem_pkg::data_w-1:0]             mem_wdata,
  input  wire [picorv_mem_pkg::strb_w-1:0]             mem_wstrb,
  output logic                                         mem_ready,
  output logic [picorv_mem_pkg::data_w-1:0]            mem_rdata,
  output logic [picorv_mem_pkg::strb_w-1:0]            ram_we,
  output logic [picorv_mem_pkg::ram_aw-1:0]            ram_addr,
  output logic [picorv_mem_pkg::data_w-1:0]            ram_wdata,
  input  wire [picorv_mem_pkg::data_w-1:0]             ram_rdata,
  output logic [picorv_mem_pkg::n_streams-1:0]         tx_start,
  output logic [picorv_mem_pkg::data_w-1:0]            tx_data,
  input  wire [picorv_mem_pkg::n_streams-1:0]          tx_done,
  output logic [picorv_mem_pkg::n_streams-1:0]         rx_start,
  input  wire [picorv_mem_pkg::n_streams-1:0]          rx_done,
  input  wire [picorv_mem_pkg::n_streams-1:0][picorv_mem_pkg::data_w-1:0] rx_data
);

  picorv_mem_pkg::bus_addr_t         addr;
  logic [picorv_mem_pkg::state_w-1:0] state;
  logic is_io;      // Address in the stream register region
  logic is_wr;      // Any strobe set
  logic is_tx;      // Write to a tx address
  logic is_rx;      // Read of an rx address
  logic chan;
  logic stream_done;

  assign addr  = mem_addr;               // Core holds it stable until mem_ready
  assign is_io = addr.io.tag == picorv_mem_pkg::io_region;
  assign is_wr = |mem_wstrb;
  assign is_tx = is_io && !addr.io.dir && is_wr;
  assign is_rx = is_io && addr.io.dir && !is_wr;
  assign chan  = addr.io.chan;

  assign stream_done = is_tx ? tx_done[chan] : rx_done[chan];

  // RAM port, written only while the access is in flight
  assign ram_addr  = addr.ram.word;      // Upper bits dropped, index wraps
  assign ram_wdata = mem_wdata;
  assign ram_we    = (state == picorv_mem_pkg::st_wait_ram && !is_io) ? mem_wstrb : '0;

  assign tx_data = mem_wdata;

  // Start pulses only from idle so a held mem_valid cannot retrigger
  always_comb begin
    tx_start = '0;
    rx_start = '0;
    if (state == picorv_mem_pkg::st_idle && mem_valid) begin
      tx_start[chan] = is_tx;
      rx_start[chan] = is_rx;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= picorv_mem_pkg::st_idle;
    end else begin
      case (state)
        picorv_mem_pkg::st_idle: begin
          if (mem_valid) begin
            // Wrong-direction I/O takes the one-cycle path with no side effect
            state <= (is_tx || is_rx) ? picorv_mem_pkg::st_wait_stream
                                      : picorv_mem_pkg::st_wait_ram;
          end
        end
        picorv_mem_pkg::st_wait_ram:    state <= picorv_mem_pkg::st_respond;  // Read lands here
        picorv_mem_pkg::st_wait_stream: begin
          if (stream_done) state <= picorv_mem_pkg::st_respond;  // Stall until handshake
        end
        default:                        state <= picorv_mem_pkg::st_idle;
      endcase
    end
  end

  assign mem_ready = state == picorv_mem_pkg::st_respond;  // One-cycle pulse

  // Read data source follows the held address
  always_comb begin
    if (!is_io) begin
      mem_rdata = ram_rdata;       // Registered RAM output
    end else if (is_rx) begin
      mem_rdata = rx_data[chan];   // Word captured by the rx port
    end else begin
      mem_rdata = '0;              // tx reads and rx writes
    end
  end

endmodule

`default_nettype wire

// File: picorv_mem.f
picorv_mem_pkg.sv
cycle_irq_timer.sv
stream_rx_port.sv
stream_tx_port.sv
byte_lane_ram.sv
mem_bus_ctrl.sv
picorv_mem_top.sv
tb_picorv_mem.sv

// File: picorv_mem_pkg.sv
`default_nettype none

package picorv_mem_pkg;

  localparam int data_w    = 32;    // Bus data width
  localparam int strb_w    = 4;     // Byte strobes per word
  localparam int ram_words = 1024;  // RAM depth in words
  localparam int ram_aw    = 10;    // Word index width

  localparam int n_streams = 2;     // Stream channels, each with a tx and an rx address

  localparam logic [3:0] io_region = 4'h1;  // Tag in mem_addr[31:28] for stream registers

  localparam int irq_fast_bit     = 4;   // Fires every 8192 cycles
  localparam int irq_slow_bit     = 5;   // Fires every 65536 cycles
  localparam int fast_period_log2 = 13;
  localparam int slow_period_log2 = 16;  // Also the cycle counter width

  // Bus controller FSM encoding
  localparam int         state_w        = 2;
  localparam logic [1:0] st_idle        = 2'd0;  // Waiting for mem_valid
  localparam logic [1:0] st_wait_ram    = 2'd1;  // RAM or no-effect access in flight
  localparam logic [1:0] st_wait_stream = 2'd2;  // Waiting for a stream done pulse
  localparam logic [1:0] st_respond     = 2'd3;  // mem_ready cycle

  // mem_addr seen either as a RAM word address or as a stream register address
  typedef union packed {
    struct packed {
      logic [data_w-ram_aw-3:0] unused;  // Ignored, index wraps
      logic [ram_aw-1:0]        word;    // Word index
      logic [1:0]               offset;  // Byte offset
    } ram;
    struct packed {
      logic [3:0]  tag;     // Region select
      logic [23:0] unused;  // Ignored inside the I/O region
      logic        chan;    // Channel number
      logic        dir;     // 0 tx, 1 rx
      logic [1:0]  offset;  // Byte offset
    } io;
  } bus_addr_t;

endpackage

`default_nettype wire

// File: picorv_mem_top.sv
`timescale 1ns/100ps
`default_nettype none

module picorv_mem_top (
  input  wire                                                clk,
  input  wire                                                resetn,
  // Core native bus
  input  wire                                                mem_valid,
  input  wire                                                mem_instr,  // Fetches served alike
  input  wire [31:0]                                         mem_addr,
  input  wire [picorv_mem_pkg::data_w-1:0]                   mem_wdata,
  input  wire [picorv_mem_pkg::strb_w-1:0]                   mem_wstrb,
  output wire                                                mem_ready,
  output wire [picorv_mem_pkg::data_w-1:0]                   mem_rdata,
  // Program loader
  input  wire                                                cfg_wr_en,
  input  wire [picorv_mem_pkg::ram_aw+1:0]                   cfg_addr,   // Byte address
  input  wire [7:0]                                          cfg_din,
  // Stream out
  output wire [picorv_mem_pkg::n_streams-1:0]                out_valid,
  output wire [picorv_mem_pkg::n_streams-1:0][picorv_mem_pkg::data_w-1:0] out_data,
  input  wire [picorv_mem_pkg::n_streams-1:0]                out_ready,
  // Stream in
  input  wire [picorv_mem_pkg::n_streams-1:0]                in_valid,
  input  wire [picorv_mem_pkg::n_streams-1:0][picorv_mem_pkg::data_w-1:0] in_data,
  output wire [picorv_mem_pkg::n_streams-1:0]                in_ready,
  output wire [31:0]                                         irq
);

  wire [picorv_mem_pkg::strb_w-1:0]    ram_we;
  wire [picorv_mem_pkg::ram_aw-1:0]    ram_addr;
  wire [picorv_mem_pkg::data_w-1:0]    ram_wdata;
  wire [picorv_mem_pkg::data_w-1:0]    ram_rdata;
  wire [picorv_mem_pkg::n_streams-1:0] tx_start;
  wire [picorv_mem_pkg::data_w-1:0]    tx_data;   // Shared by all tx channels
  wire [picorv_mem_pkg::n_streams-1:0] tx_done;
  wire [picorv_mem_pkg::n_streams-1:0] rx_start;
  wire [picorv_mem_pkg::n_streams-1:0] rx_done;
  wire [picorv_mem_pkg::n_streams-1:0][picorv_mem_pkg::data_w-1:0] rx_data;

  mem_bus_ctrl mem_bus_ctrl_i (
    .clk       (clk),
    .resetn    (resetn),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata),
    .tx_start  (tx_start),
    .tx_data   (tx_data),
    .tx_done   (tx_done),
    .rx_start  (rx_start),
    .rx_done   (rx_done),
    .rx_data   (rx_data)
  );

  byte_lane_ram byte_lane_ram_i (
    .clk       (clk),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata),
    .cfg_wr_en (cfg_wr_en),
    .cfg_addr  (cfg_addr),
    .cfg_din   (cfg_din)
  );

  for (genvar ch = 0; ch < picorv_mem_pkg::n_streams; ch++) begin : g_stream
    stream_tx_port stream_tx_port_i (
      .clk       (clk),
      .resetn    (resetn),
      .tx_start  (tx_start[ch]),
      .tx_data   (tx_data),
      .out_ready (out_ready[ch]),
      .out_valid (out_valid[ch]),
      .out_data  (out_data[ch]),
      .tx_done   (tx_done[ch])
    );

    stream_rx_port stream_rx_port_i (
      .clk      (clk),
      .resetn   (resetn),
      .rx_start (rx_start[ch]),
      .in_valid (in_valid[ch]),
      .in_data  (in_data[ch]),
      .in_ready (in_ready[ch]),
      .rx_done  (rx_done[ch]),
      .rx_data  (rx_data[ch])
    );
  end

  cycle_irq_timer cycle_irq_timer_i (
    .clk    (clk),
    .resetn (resetn),
    .irq    (irq)
  );

endmodule

`default_nettype wire

// File: stream_rx_port.sv
`timescale 1ns/100ps
`default_nettype none

module stream_rx_port (
  input  wire                               clk,
  input  wire                               resetn,
  input  wire                               rx_start,
  input  wire                               in_valid,
  input  wire [picorv_mem_pkg::data_w-1:0]  in_data,
  output logic                              in_ready,
  output logic                              rx_done,
  output logic [picorv_mem_pkg::data_w-1:0] rx_data
);

  logic xfer;

  assign xfer = in_ready && in_valid;  // Handshake edge

  always_ff @(posedge clk) begin
    if (!resetn) begin
      in_ready <= 1'b0;
      rx_done  <= 1'b0;
    end else begin
      rx_done <= xfer;                 // One cycle after the transfer
      if (rx_start) begin
        in_ready <= 1'b1;              // A bus read is waiting
      end else if (xfer) begin
        in_ready <= 1'b0;              // Exactly one word per read
      end
    end
  end

  // Captured word stays until the next transfer, past mem_ready
  always_ff @(posedge clk) begin
    if (xfer) rx_data <= in_data;
  end

endmodule

`default_nettype wire

// File: stream_tx_port.sv
`timescale 1ns/100ps
`default_nettype none

module stream_tx_port (
  input  wire                               clk,
  input  wire                               resetn,
  input  wire                               tx_start,
  input  wire [picorv_mem_pkg::data_w-1:0]  tx_data,
  input  wire                               out_ready,
  output logic                              out_valid,
  output logic [picorv_mem_pkg::data_w-1:0] out_data,
  output logic                              tx_done
);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      out_valid <= 1'b0;
      tx_done   <= 1'b0;
    end else begin
      tx_done <= 1'b0;                    // Pulse by default
      if (tx_start) begin
        out_valid <= 1'b1;
      end else if (out_valid && out_ready) begin
        out_valid <= 1'b0;                // Sink took the word
        tx_done   <= 1'b1;
      end
    end
  end

  // Word held stable while out_valid waits
  always_ff @(posedge clk) begin
    if (tx_start) out_data <= tx_data;
  end

endmodule

`default_nettype wire

// File: tb_picorv_mem.sv
`timescale 1ns/100ps
`default_nettype none

module tb_picorv_mem;

  localparam logic [2:0] op_load  = 3'd0;  // Loader byte write
  localparam logic [2:0] op_write = 3'd1;
  localparam logic [2:0] op_read  = 3'd2;
  localparam logic [2:0] op_send  = 3'd3;  // Bus write to a tx address
  localparam logic [2:0] op_recv  = 3'd4;  // Bus read of an rx address
  localparam int n_rows   = 19;
  localparam int irq_span = 65540;         // Just past the first slow interrupt
  localparam int timeout_cycles = 16 + irq_span + 200 * n_rows;

  typedef struct packed {
    logic [2:0]  op;
    logic [31:0] addr;
    logic [31:0] data;      // Loader byte in [7:0] or source word for receives
    logic [3:0]  strb;
    logic [31:0] expected;  // Expected I/O read data
  } row_t;

  logic              clk = 1'b0;
  logic              resetn;
  logic              mem_valid;
  logic              mem_instr;
  logic [31:0]       mem_addr;
  logic [31:0]       mem_wdata;
  logic [3:0]        mem_wstrb;
  wire               mem_ready;
  wire  [31:0]       mem_rdata;
  logic              cfg_wr_en;
  logic [11:0]       cfg_addr;
  logic [7:0]        cfg_din;
  wire  [1:0]        out_valid;
  wire  [1:0][31:0]  out_data;
  logic [1:0]        out_ready = '0;  // Sink model drives it
  logic [1:0]        in_valid = '0;   // Source model drives it
  logic [1:0][31:0]  in_data = '0;
  wire  [1:0]        in_ready;
  wire  [31:0]       irq;

  row_t        rows [n_rows];
  logic [31:0] ref_mem [1024];        // Expected RAM contents
  logic [32:0] sent_log [$];          // {channel, word} per accepted out transfer
  logic [31:0] src_word [2];
  int          src_offered [2] = '{0, 0};  // Words handed to the source
  int          rx_count [2] = '{0, 0};     // In transfers seen
  logic [15:0] lfsr = 16'd62;
  int          irq_count = 0;              // Cycles since reset release
  int          cycles = 0;

  picorv_mem_top picorv_mem_top_i (.*);

  initial begin
    forever #50 clk = ~clk;
  end

  function automatic logic next_bit();
    lfsr = lfsr[0] ? (lfsr >> 1) ^ 16'hB400 : lfsr >> 1;  // Galois step with taps 16 14 13 11
    return lfsr[0];
  endfunction

  function automatic logic [31:0] irq_expect(input int n);
    logic [31:0] v;
    v    = '0;
    v[4] = (n % 8192) == 8191;
    v[5] = (n % 65536) == 65535;
    return v;
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      $display("Errors found");
      $fatal(1, "check failed");
    end
  endtask

  task automatic load_byte(input logic [11:0] a, input logic [7:0] d);
    @(negedge clk);
    cfg_wr_en = 1'b1;
    cfg_addr  = a;
    cfg_din   = d;
    @(negedge clk);
    cfg_wr_en = 1'b0;
  endtask

  task automatic bus_access(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [31:0] rdata, output int lat);
    @(negedge clk);
    mem_valid = 1'b1;
    mem_instr = strb == 4'h0;  // Reads posed as fetches that the DUT ignores
    mem_addr  = addr;
    mem_wdata = data;
    mem_wstrb = strb;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!mem_ready);
    rdata     = mem_rdata;
    mem_valid = 1'b0;
  endtask

  task automatic run_row(input int r);
    row_t        row;
    logic [31:0] rdata;
    logic [9:0]  word;
    int          lat;
    int          lane;
    int          ch;
    int          tx_base;
    int          rx_base [2];
    logic        io;
    string       name;
    row     = rows[r];
    name    = $sformatf("row %0d", r);
    word    = row.addr[11:2];  // Wraps modulo 1024
    lane    = int'(row.addr[1:0]);
    ch      = int'(row.addr[3]);
    io      = row.addr[31:28] == 4'h1;
    tx_base = sent_log.size();
    rx_base = rx_count;
    if (row.op == op_load) begin
      load_byte(row.addr[11:0], row.data[7:0]);
      ref_mem[word][8*lane +: 8] = row.data[7:0];
    end else begin
      if (row.op == op_recv) begin
        src_word[ch] = row.data;
        src_offered[ch]++;
      end
      bus_access(row.addr, row.data, row.strb, rdata, lat);
      if (row.op == op_write && !io) begin
        for (int b = 0; b < 4; b++) begin
          if (row.strb[b]) ref_mem[word][8*b +: 8] = row.data[8*b +: 8];  // Strobed lanes only
        end
      end
      if (row.op == op_read || row.op == op_recv) begin
        check(name, io ? row.expected : ref_mem[word], rdata);
      end
      if (row.op == op_send || row.op == op_recv) begin
        check({name, " stream latency"}, 32'd1, 32'(lat > 2));
      end else begin
        check({name, " latency"}, 32'd2, 32'(lat));  // Ready one cycle after first sample
      end
      check({name, " tx count"}, 32'(row.op == op_send), 32'(sent_log.size() - tx_base));
      if (row.op == op_send) begin
        check({name, " tx word"}, row.data, sent_log[tx_base][31:0]);
        check({name, " tx channel"}, 32'(ch), 32'(sent_log[tx_base][32]));
      end
      check({name, " rx count"}, 32'(row.op == op_recv), 32'(rx_count[ch] - rx_base[ch]));
      check({name, " stream idle"}, 32'd0, 32'({out_valid, in_ready}));
    end
  endtask

  // Sink and source with random stalls decide the transfer at the coming edge
  always @(negedge clk) begin
    for (int ch = 0; ch < 2; ch++) begin
      out_ready[ch] = next_bit();
      if (out_valid[ch] && out_ready[ch]) sent_log.push_back({1'(ch), out_data[ch]});
      if (src_offered[ch] > rx_count[ch]) begin
        in_valid[ch] = next_bit();
        in_data[ch]  = src_word[ch];
        if (in_valid[ch] && in_ready[ch]) rx_count[ch]++;
      end else begin
        in_valid[ch] = 1'b0;
      end
    end
  end

  always @(posedge clk) irq_count <= resetn ? irq_count + 1 : 0;

  always @(negedge clk) check("irq", irq_expect(irq_count), irq);

  always @(negedge clk) begin
    cycles++;
    if (cycles > timeout_cycles) begin
      $display("Timeout after %0d cycles, a bus access or the run never finished", cycles);
      $display("Errors found");
      $fatal(1, "timeout");
    end
  end

  initial begin
    resetn    = 1'b0;
    mem_valid = 1'b0;
    mem_instr = 1'b0;
    mem_addr  = '0;
    mem_wdata = '0;
    mem_wstrb = '0;
    cfg_wr_en = 1'b0;
    cfg_addr  = '0;
    cfg_din   = '0;
    rows[0]  = '{op_write, 32'h0000_0010, 32'h1122_3344, 4'hF, 32'h0};
    rows[1]  = '{op_load,  32'h0000_0010, 32'h0000_005A, 4'h0, 32'h0};
    rows[2]  = '{op_load,  32'h0000_0011, 32'h0000_006B, 4'h0, 32'h0};
    rows[3]  = '{op_load,  32'h0000_0012, 32'h0000_007C, 4'h0, 32'h0};
    rows[4]  = '{op_load,  32'h0000_0013, 32'h0000_008D, 4'h0, 32'h0};
    rows[5]  = '{op_read,  32'h0000_0010, 32'h0,         4'h0, 32'h0};
    rows[6]  = '{op_write, 32'h0000_0FFC, 32'hDEAD_BEEF, 4'hF, 32'h0};
    rows[7]  = '{op_write, 32'h0000_1FFC, 32'h0102_0304, 4'h5, 32'h0};  // Wraps to word 1023
    rows[8]  = '{op_read,  32'h0000_0FFC, 32'h0,         4'h0, 32'h0};
    rows[9]  = '{op_write, 32'h0000_0020, 32'hCAFE_F00D, 4'hF, 32'h0};
    rows[10] = '{op_write, 32'h8000_0020, 32'h9988_7766, 4'hA, 32'h0};  // Tag 8 is RAM
    rows[11] = '{op_read,  32'h0000_0020, 32'h0,         4'h0, 32'h0};
    rows[12] = '{op_send,  32'h1000_0000, 32'h0BAD_C0DE, 4'hF, 32'h0};
    rows[13] = '{op_send,  32'h1000_0008, 32'h1234_5678, 4'hF, 32'h0};
    rows[14] = '{op_recv,  32'h1000_0004, 32'h1357_9BDF, 4'h0, 32'h1357_9BDF};
    rows[15] = '{op_recv,  32'h1ABC_DE0C, 32'h2468_ACE0, 4'h0, 32'h2468_ACE0};
    rows[16] = '{op_read,  32'h1000_0008, 32'h0,         4'h0, 32'h0};  // tx read gives zero
    rows[17] = '{op_write, 32'h1000_000C, 32'h5555_5555, 4'hF, 32'h0};  // rx write has no effect
    rows[18] = '{op_read,  32'h0000_0010, 32'h0,         4'h0, 32'h0};
    repeat (16) @(negedge clk);
    resetn = 1'b1;
    for (int r = 0; r < n_rows; r++) begin
      run_row(r);
    end
    while (irq_count < irq_span) @(negedge clk);  // Let both interrupts fire once
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire
